// ==== mips_pkg.sv ====
package mips_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_SLTU,
                ALU_LUI
        } alu_op_e;

        // major opcodes in inst[31:26]
        localparam logic [5:0] OPC_SPECIAL = 6'h00;
        localparam logic [5:0] OPC_ADDIU   = 6'h09;
        localparam logic [5:0] OPC_ANDI    = 6'h0c;
        localparam logic [5:0] OPC_ORI     = 6'h0d;
        localparam logic [5:0] OPC_LUI     = 6'h0f;
        localparam logic [5:0] OPC_LW      = 6'h23;
        localparam logic [5:0] OPC_SW      = 6'h2b;

        // SPECIAL function codes in inst[5:0]
        localparam logic [5:0] FN_ADDU = 6'h21;
        localparam logic [5:0] FN_SUBU = 6'h23;
        localparam logic [5:0] FN_AND  = 6'h24;
        localparam logic [5:0] FN_OR   = 6'h25;
        localparam logic [5:0] FN_XOR  = 6'h26;
        localparam logic [5:0] FN_SLT  = 6'h2a;
        localparam logic [5:0] FN_SLTU = 6'h2b;

        typedef struct packed {
                alu_op_e   alu_op;
                word_t     op_a;
                word_t     op_b;
                word_t     st_data;
                reg_addr_t rd;
                logic      wr;
                logic      ld;
                logic      st;
        } id_ex_t;

        typedef struct packed {
                word_t     result;      // alu result or memory address
                word_t     st_data;
                reg_addr_t rd;
                logic      wr;
                logic      ld;
                logic      st;
        } ex_mm_t;

        typedef struct packed {
                word_t     result;
                reg_addr_t rd;
                logic      wr;
        } mm_wb_t;

endpackage

// ==== stage_reg.sv ====
`timescale 1ns/100ps

module stage_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     en_i,
        input  logic     bubble_i,
        input  payload_t d_i,
        output payload_t q_o
);

        // all-zero payload has every flag clear, so it acts as a bubble
        always_ff @(posedge clk) begin
                if (!rst_n || bubble_i) begin
                        q_o <= '0;
                end else if (en_i) begin
                        q_o <= d_i;
                end
        end

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/100ps

module pipe_ctrl import mips_pkg::*; (
        input  logic      dbus_stall_i,
        input  logic      ibus_stall_i,
        input  logic      ex_load_i,
        input  reg_addr_t ex_rd_i,
        input  logic      mm_load_i,
        input  reg_addr_t mm_rd_i,
        input  reg_addr_t id_rs_i,
        input  reg_addr_t id_rt_i,
        output logic      en_pc_o,
        output logic      en_ifid_o,
        output logic      en_idex_o,
        output logic      en_exmm_o,
        output logic      en_mmwb_o
);

        logic ex_hit;
        logic mm_hit;
        logic load_use;

        assign ex_hit = ex_load_i && (ex_rd_i != '0) &&
                        (ex_rd_i == id_rs_i || ex_rd_i == id_rt_i);
        assign mm_hit = mm_load_i && (mm_rd_i != '0) &&
                        (mm_rd_i == id_rs_i || mm_rd_i == id_rt_i);
        assign load_use = ex_hit || mm_hit;

        always_comb begin
                if (dbus_stall_i) begin
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00000;
                end else if (load_use || ibus_stall_i) begin
                        // hold decode, let execute and later drain
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00011;
                end else begin
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b11111;
                end
        end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import mips_pkg::*; #(
        parameter word_t RESET_PC = '0
) (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  en_pc_i,
        input  logic  en_ifid_i,
        input  logic  en_idex_i,
        output word_t ibus_address_o,
        output logic  ibus_read_o,
        input  word_t ibus_rddata_i,
        input  logic  ibus_stall_i,
        output word_t inst_o
);

        word_t pc_q;
        word_t hold_addr_q;
        word_t inst_q;
        logic  run_q;
        logic  hold_q;

        assign ibus_read_o    = run_q;  // first fetch one cycle after reset
        assign ibus_address_o = hold_q ? hold_addr_q : pc_q;
        assign inst_o         = inst_q;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pc_q   <= RESET_PC;
                        run_q  <= 1'b0;
                        hold_q <= 1'b0;
                end else begin
                        run_q  <= 1'b1;
                        hold_q <= ibus_read_o && ibus_stall_i;
                        if (en_pc_i && ibus_read_o)
                                pc_q <= pc_q + 32'd4;
                end
        end

        // latch the address on the first cycle of each fetch
        always_ff @(posedge clk) begin
                if (!hold_q && ibus_read_o)
                        hold_addr_q <= pc_q;
        end

        always_ff @(posedge clk) begin
                if (!rst_n || (!en_ifid_i && en_idex_i)) begin
                        inst_q <= '0;   // nop bubble
                end else if (en_ifid_i) begin
                        inst_q <= ibus_read_o ? ibus_rddata_i : '0;
                end
        end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file import mips_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  reg_addr_t raddr1_i,
        input  reg_addr_t raddr2_i,
        output word_t     rdata1_o,
        output word_t     rdata2_o,
        input  logic      we_i,
        input  reg_addr_t waddr_i,
        input  word_t     wdata_i
);

        word_t regs [32];

        // r0 is cleared by reset and never written
        assign rdata1_o = regs[raddr1_i];
        assign rdata2_o = regs[raddr2_i];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        for (int i = 0; i < 32; i++)
                                regs[i] <= '0;
                end else if (we_i && waddr_i != '0) begin
                        regs[waddr_i] <= wdata_i;
                end
        end

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit import mips_pkg::*; (
        input  word_t     inst_i,
        output reg_addr_t rs_o,
        output reg_addr_t rt_o,
        input  word_t     rs_val_i,
        input  word_t     rt_val_i,
        input  ex_mm_t    ex_fwd_i,
        input  mm_wb_t    mm_fwd_i,
        input  mm_wb_t    wb_fwd_i,
        output id_ex_t    decoded_o
);

        logic [5:0] opcode;
        logic [5:0] funct;
        reg_addr_t  rd;
        word_t      imm_sx;
        word_t      imm_zx;
        word_t      rs_fwd;
        word_t      rt_fwd;

        assign opcode = inst_i[31:26];
        assign funct  = inst_i[5:0];
        assign rs_o   = inst_i[25:21];
        assign rt_o   = inst_i[20:16];
        assign rd     = inst_i[15:11];
        assign imm_sx = {{16{inst_i[15]}}, inst_i[15:0]};
        assign imm_zx = {16'b0, inst_i[15:0]};

        // youngest writer wins; a load in execute is covered by the interlock
        function automatic word_t pick(reg_addr_t r, word_t rf_val, ex_mm_t ex,
                                       mm_wb_t mm, mm_wb_t wb);
                if (r == '0)
                        return rf_val;
                if (ex.wr && !ex.ld && ex.rd == r)
                        return ex.result;
                if (mm.wr && mm.rd == r)
                        return mm.result;
                if (wb.wr && wb.rd == r)
                        return wb.result;
                return rf_val;
        endfunction

        assign rs_fwd = pick(rs_o, rs_val_i, ex_fwd_i, mm_fwd_i, wb_fwd_i);
        assign rt_fwd = pick(rt_o, rt_val_i, ex_fwd_i, mm_fwd_i, wb_fwd_i);

        always_comb begin
                decoded_o         = '0;         // unknown encodings fall out as nop
                decoded_o.alu_op  = ALU_ADD;
                decoded_o.op_a    = rs_fwd;
                decoded_o.op_b    = rt_fwd;
                decoded_o.st_data = rt_fwd;
                decoded_o.rd      = rd;
                case (opcode)
                        OPC_SPECIAL: begin
                                decoded_o.wr = 1'b1;
                                case (funct)
                                        FN_ADDU: decoded_o.alu_op = ALU_ADD;
                                        FN_SUBU: decoded_o.alu_op = ALU_SUB;
                                        FN_AND:  decoded_o.alu_op = ALU_AND;
                                        FN_OR:   decoded_o.alu_op = ALU_OR;
                                        FN_XOR:  decoded_o.alu_op = ALU_XOR;
                                        FN_SLT:  decoded_o.alu_op = ALU_SLT;
                                        FN_SLTU: decoded_o.alu_op = ALU_SLTU;
                                        default: decoded_o.wr = 1'b0;
                                endcase
                        end
                        OPC_ADDIU: begin
                                decoded_o.op_b = imm_sx;
                                decoded_o.rd   = rt_o;
                                decoded_o.wr   = 1'b1;
                        end
                        OPC_ANDI: begin
                                decoded_o.alu_op = ALU_AND;
                                decoded_o.op_b   = imm_zx;
                                decoded_o.rd     = rt_o;
                                decoded_o.wr     = 1'b1;
                        end
                        OPC_ORI: begin
                                decoded_o.alu_op = ALU_OR;
                                decoded_o.op_b   = imm_zx;
                                decoded_o.rd     = rt_o;
                                decoded_o.wr     = 1'b1;
                        end
                        OPC_LUI: begin
                                decoded_o.alu_op = ALU_LUI;
                                decoded_o.op_b   = imm_zx;
                                decoded_o.rd     = rt_o;
                                decoded_o.wr     = 1'b1;
                        end
                        OPC_LW: begin
                                decoded_o.op_b = imm_sx;    // base + offset
                                decoded_o.rd   = rt_o;
                                decoded_o.wr   = 1'b1;
                                decoded_o.ld   = 1'b1;
                        end
                        OPC_SW: begin
                                decoded_o.op_b = imm_sx;
                                decoded_o.st   = 1'b1;
                        end
                        default: ;
                endcase
        end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit import mips_pkg::*; (
        input  id_ex_t idex_i,
        output ex_mm_t exmm_o
);

        word_t a;
        word_t b;
        word_t res;

        assign a = idex_i.op_a;
        assign b = idex_i.op_b;

        // loads and stores decode to ALU_ADD, so res is their address
        always_comb begin
                case (idex_i.alu_op)
                        ALU_ADD:  res = a + b;
                        ALU_SUB:  res = a - b;
                        ALU_AND:  res = a & b;
                        ALU_OR:   res = a | b;
                        ALU_XOR:  res = a ^ b;
                        ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                        ALU_SLTU: res = {31'b0, a < b};
                        ALU_LUI:  res = {b[15:0], 16'b0};
                        default:  res = '0;
                endcase
        end

        always_comb begin
                exmm_o.result  = res;
                exmm_o.st_data = idex_i.st_data;
                exmm_o.rd      = idex_i.rd;
                exmm_o.wr      = idex_i.wr;
                exmm_o.ld      = idex_i.ld;
                exmm_o.st      = idex_i.st;
        end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage import mips_pkg::*; (
        input  ex_mm_t exmm_i,
        output word_t  dbus_address_o,
        output logic   dbus_read_o,
        output logic   dbus_write_o,
        output word_t  dbus_wrdata_o,
        input  word_t  dbus_rddata_i,
        output mm_wb_t mmwb_o
);

        // held stable by the pipeline freeze during a stall
        assign dbus_address_o = exmm_i.result;
        assign dbus_read_o    = exmm_i.ld;
        assign dbus_write_o   = exmm_i.st;
        assign dbus_wrdata_o  = exmm_i.st_data;

        always_comb begin
                mmwb_o.result = exmm_i.ld ? dbus_rddata_i : exmm_i.result;
                mmwb_o.rd     = exmm_i.rd;
                mmwb_o.wr     = exmm_i.wr;
        end

endmodule

// ==== mips_core.sv ====
`timescale 1ns/100ps

module mips_core import mips_pkg::*; #(
        parameter word_t RESET_PC = '0
) (
        input  logic  clk,
        input  logic  rst_n,
        output word_t ibus_address_o,
        output logic  ibus_read_o,
        input  word_t ibus_rddata_i,
        input  logic  ibus_stall_i,
        output word_t dbus_address_o,
        output logic  dbus_read_o,
        output logic  dbus_write_o,
        output word_t dbus_wrdata_o,
        input  word_t dbus_rddata_i,
        input  logic  dbus_stall_i
);

        logic      en_pc;
        logic      en_ifid;
        logic      en_idex;
        logic      en_exmm;
        logic      en_mmwb;
        word_t     inst;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     rs_val;
        word_t     rt_val;
        id_ex_t    id_d;
        id_ex_t    id_q;
        ex_mm_t    ex_d;
        ex_mm_t    ex_q;
        mm_wb_t    mm_d;
        mm_wb_t    wb_q;

        pipe_ctrl ctrl0 (
                .dbus_stall_i(dbus_stall_i),
                .ibus_stall_i(ibus_stall_i),
                .ex_load_i   (ex_d.ld),
                .ex_rd_i     (ex_d.rd),
                .mm_load_i   (ex_q.ld),
                .mm_rd_i     (ex_q.rd),
                .id_rs_i     (rs),
                .id_rt_i     (rt),
                .en_pc_o     (en_pc),
                .en_ifid_o   (en_ifid),
                .en_idex_o   (en_idex),
                .en_exmm_o   (en_exmm),
                .en_mmwb_o   (en_mmwb)
        );

        fetch_unit #(.RESET_PC(RESET_PC)) fetch0 (
                .clk           (clk),
                .rst_n         (rst_n),
                .en_pc_i       (en_pc),
                .en_ifid_i     (en_ifid),
                .en_idex_i     (en_idex),
                .ibus_address_o(ibus_address_o),
                .ibus_read_o   (ibus_read_o),
                .ibus_rddata_i (ibus_rddata_i),
                .ibus_stall_i  (ibus_stall_i),
                .inst_o        (inst)
        );

        reg_file regs0 (
                .clk     (clk),
                .rst_n   (rst_n),
                .raddr1_i(rs),
                .raddr2_i(rt),
                .rdata1_o(rs_val),
                .rdata2_o(rt_val),
                .we_i    (wb_q.wr),
                .waddr_i (wb_q.rd),
                .wdata_i (wb_q.result)
        );

        decode_unit decode0 (
                .inst_i   (inst),
                .rs_o     (rs),
                .rt_o     (rt),
                .rs_val_i (rs_val),
                .rt_val_i (rt_val),
                .ex_fwd_i (ex_d),
                .mm_fwd_i (mm_d),
                .wb_fwd_i (wb_q),
                .decoded_o(id_d)
        );

        stage_reg #(.payload_t(id_ex_t)) idex_reg (
                .clk     (clk),
                .rst_n   (rst_n),
                .en_i    (en_idex),
                .bubble_i(!en_idex && en_exmm),
                .d_i     (id_d),
                .q_o     (id_q)
        );

        exec_unit exec0 (
                .idex_i(id_q),
                .exmm_o(ex_d)
        );

        stage_reg #(.payload_t(ex_mm_t)) exmm_reg (
                .clk     (clk),
                .rst_n   (rst_n),
                .en_i    (en_exmm),
                .bubble_i(!en_exmm && en_mmwb),
                .d_i     (ex_d),
                .q_o     (ex_q)
        );

        mem_stage mem0 (
                .exmm_i        (ex_q),
                .dbus_address_o(dbus_address_o),
                .dbus_read_o   (dbus_read_o),
                .dbus_write_o  (dbus_write_o),
                .dbus_wrdata_o (dbus_wrdata_o),
                .dbus_rddata_i (dbus_rddata_i),
                .mmwb_o        (mm_d)
        );

        // writeback takes a bubble on every frozen cycle
        stage_reg #(.payload_t(mm_wb_t)) mmwb_reg (
                .clk     (clk),
                .rst_n   (rst_n),
                .en_i    (en_mmwb),
                .bubble_i(!en_mmwb),
                .d_i     (mm_d),
                .q_o     (wb_q)
        );

endmodule

// ==== mips_assertions.sv ====
`timescale 1ns/100ps

module mips_assertions import mips_pkg::*; (
        input logic  clk,
        input logic  rst_n,
        input word_t ibus_address_i,
        input logic  ibus_read_i,
        input logic  ibus_stall_i,
        input word_t dbus_address_i,
        input logic  dbus_read_i,
        input logic  dbus_write_i,
        input word_t dbus_wrdata_i,
        input logic  dbus_stall_i
);

        ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
                ibus_read_i && ibus_stall_i |=> ibus_read_i && $stable(ibus_address_i))
                else $error("ibus address or strobe changed during stall");

        dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
                (dbus_read_i || dbus_write_i) && dbus_stall_i |=>
                $stable(dbus_address_i) && $stable(dbus_read_i) &&
                $stable(dbus_write_i) && $stable(dbus_wrdata_i))
                else $error("dbus access changed during stall");

        dbus_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_read_i && dbus_write_i))
                else $error("dbus read and write strobes both high");

        // strobes are cleared by the first reset edge
        reset_quiet: assert property (@(posedge clk)
                !rst_n |=> !ibus_read_i && !dbus_read_i && !dbus_write_i)
                else $error("bus strobe high during reset");

endmodule

bind mips_core mips_assertions asrt0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .ibus_address_i(ibus_address_o),
        .ibus_read_i   (ibus_read_o),
        .ibus_stall_i  (ibus_stall_i),
        .dbus_address_i(dbus_address_o),
        .dbus_read_i   (dbus_read_o),
        .dbus_write_i  (dbus_write_o),
        .dbus_wrdata_i (dbus_wrdata_o),
        .dbus_stall_i  (dbus_stall_i)
);

// ==== tb_mips.sv ====
`timescale 1ns/100ps

module tb_mips import mips_pkg::*; ();

        localparam int    NUM_INST = 200;
        localparam int    TIMEOUT  = NUM_INST * 8 + 100;
        localparam word_t RESET_PC = 32'h0000_0000;

        logic  clk;
        logic  rst_n;
        word_t ibus_address;
        logic  ibus_read;
        word_t ibus_rddata;
        logic  ibus_stall;
        word_t dbus_address;
        logic  dbus_read;
        logic  dbus_write;
        word_t dbus_wrdata;
        word_t dbus_rddata;
        logic  dbus_stall;

        word_t imem [NUM_INST];
        word_t dmem [256];
        word_t ref_mem [256];
        word_t ref_regs [32];
        word_t exp_addr [$];
        word_t exp_data [$];
        word_t exp_load [$];

        logic [31:0] seed = 32'd90082;
        int    cycles = 0;
        int    store_errs = 0;
        int    load_errs = 0;
        int    fetch_errs = 0;
        int    count_errs = 0;
        int    n_stores = 0;
        int    n_exp = 0;
        logic  first_fetch = 1'b1;
        word_t last_fetch;
        logic  prev_istall = 1'b0;
        word_t prev_iaddr;

        mips_core #(.RESET_PC(RESET_PC)) dut0 (
                .clk           (clk),
                .rst_n         (rst_n),
                .ibus_address_o(ibus_address),
                .ibus_read_o   (ibus_read),
                .ibus_rddata_i (ibus_rddata),
                .ibus_stall_i  (ibus_stall),
                .dbus_address_o(dbus_address),
                .dbus_read_o   (dbus_read),
                .dbus_write_o  (dbus_write),
                .dbus_wrdata_o (dbus_wrdata),
                .dbus_rddata_i (dbus_rddata),
                .dbus_stall_i  (dbus_stall)
        );

        initial clk = 1'b0;
        always #20 clk = ~clk;

        function automatic word_t lcg();
                seed = seed * 32'd1664525 + 32'd1013904223;
                return seed;
        endfunction

        function automatic int unsigned rand_below(int unsigned n);
                return (lcg() >> 16) % n;
        endfunction

        // instructions past the program read as nop
        function automatic word_t fetch_word(word_t addr);
                word_t idx;
                idx = (addr - RESET_PC) >> 2;
                if (idx < NUM_INST)
                        return imem[idx];
                return '0;
        endfunction

        task automatic build_program();
                int unsigned kind;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [15:0] imm;
                logic [15:0] woff;
                logic [5:0]  fn;
                for (int i = 0; i < NUM_INST - 7; i++) begin
                        kind = rand_below(13);
                        rs   = 5'(rand_below(8));       // r0..r7 keeps hazards dense
                        rt   = 5'(rand_below(8));
                        rd   = 5'(rand_below(8));
                        imm  = 16'(lcg() >> 8);
                        woff = 16'(rand_below(256) * 4);
                        case (kind)
                                0: fn = FN_ADDU;
                                1: fn = FN_SUBU;
                                2: fn = FN_AND;
                                3: fn = FN_OR;
                                4: fn = FN_XOR;
                                5: fn = FN_SLT;
                                default: fn = FN_SLTU;
                        endcase
                        case (kind)
                                7:  imem[i] = {OPC_ADDIU, rs, rt, imm};
                                8:  imem[i] = {OPC_ANDI, rs, rt, imm};
                                9:  imem[i] = {OPC_ORI, rs, rt, imm};
                                10: imem[i] = {OPC_LUI, 5'd0, rt, imm};
                                11: imem[i] = {OPC_LW, 5'd0, rt, woff};
                                12: imem[i] = {OPC_SW, 5'd0, rt, woff};
                                default: imem[i] = {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
                        endcase
                end
                // dump r1..r7 to the top of data memory
                for (int r = 1; r <= 7; r++)
                        imem[NUM_INST - 8 + r] = {OPC_SW, 5'd0, 5'(r), 16'((247 + r) * 4)};
        endtask

        task automatic run_model();
                word_t      inst;
                logic [5:0] op;
                word_t      a;
                word_t      b;
                word_t      sx;
                word_t      zx;
                word_t      val;
                logic [4:0] dest;
                logic       wr;
                for (int i = 0; i < NUM_INST; i++) begin
                        inst = imem[i];
                        op   = inst[31:26];
                        a    = ref_regs[inst[25:21]];
                        b    = ref_regs[inst[20:16]];
                        sx   = {{16{inst[15]}}, inst[15:0]};
                        zx   = {16'd0, inst[15:0]};
                        dest = inst[20:16];
                        wr   = 1'b1;
                        val  = '0;
                        case (op)
                                OPC_SPECIAL: begin
                                        dest = inst[15:11];
                                        case (inst[5:0])
                                                FN_ADDU: val = a + b;
                                                FN_SUBU: val = a - b;
                                                FN_AND:  val = a & b;
                                                FN_OR:   val = a | b;
                                                FN_XOR:  val = a ^ b;
                                                FN_SLT:  val = ($signed(a) < $signed(b)) ? 1 : 0;
                                                FN_SLTU: val = (a < b) ? 1 : 0;
                                                default: wr = 1'b0;
                                        endcase
                                end
                                OPC_ADDIU: val = a + sx;
                                OPC_ANDI:  val = a & zx;
                                OPC_ORI:   val = a | zx;
                                OPC_LUI:   val = {inst[15:0], 16'd0};
                                OPC_LW: begin
                                        val = ref_mem[(a + sx) >> 2 & 32'hff];
                                        exp_load.push_back(a + sx);
                                end
                                OPC_SW: begin
                                        wr = 1'b0;
                                        ref_mem[(a + sx) >> 2 & 32'hff] = b;
                                        exp_addr.push_back(a + sx);
                                        exp_data.push_back(b);
                                end
                                default: wr = 1'b0;
                        endcase
                        if (wr && dest != 0)
                                ref_regs[dest] = val;
                end
        endtask

        // memory models answer 2 ns after the edge
        always @(posedge clk) begin
                #2;
                ibus_stall  = (rand_below(4) == 0);
                dbus_stall  = (rand_below(4) == 0);
                ibus_rddata = fetch_word(ibus_address);
                dbus_rddata = dmem[dbus_address[9:2]];
        end

        always @(negedge clk) begin
                if (rst_n) begin
                        if (prev_istall && ibus_address != prev_iaddr) begin
                                $display("Error: ibus_address_o moved during stall %h -> %h",
                                         prev_iaddr, ibus_address);
                                fetch_errs++;
                        end
                        prev_istall = ibus_read && ibus_stall;
                        prev_iaddr  = ibus_address;
                        if (ibus_read && !ibus_stall) begin
                                if (first_fetch && ibus_address != RESET_PC) begin
                                        $display("Error: ibus_address_o got %h expected %h",
                                                 ibus_address, RESET_PC);
                                        fetch_errs++;
                                end else if (!first_fetch && ibus_address != last_fetch &&
                                             ibus_address != last_fetch + 4) begin
                                        $display("Error: ibus_address_o got %h expected %h",
                                                 ibus_address, last_fetch + 4);
                                        fetch_errs++;
                                end
                                first_fetch = 1'b0;
                                last_fetch  = ibus_address;
                        end
                        if (dbus_read && !dbus_stall) begin
                                if (exp_load.size() == 0) begin
                                        $display("load from %h that the program never made",
                                                 dbus_address);
                                        load_errs++;
                                end else begin
                                        if (dbus_address != exp_load[0]) begin
                                                $display("Error: dbus_address_o got %h expected %h",
                                                         dbus_address, exp_load[0]);
                                                load_errs++;
                                        end
                                        void'(exp_load.pop_front());
                                end
                        end
                        if (dbus_write && !dbus_stall) begin
                                dmem[dbus_address[9:2]] = dbus_wrdata;
                                n_stores++;
                                if (exp_addr.size() == 0) begin
                                        $display("store to %h that the program never made",
                                                 dbus_address);
                                        store_errs++;
                                end else begin
                                        if (dbus_address != exp_addr[0]) begin
                                                $display("Error: dbus_address_o got %h expected %h",
                                                         dbus_address, exp_addr[0]);
                                                store_errs++;
                                        end
                                        if (dbus_wrdata != exp_data[0]) begin
                                                $display("Error: dbus_wrdata_o got %h expected %h",
                                                         dbus_wrdata, exp_data[0]);
                                                store_errs++;
                                        end
                                        void'(exp_addr.pop_front());
                                        void'(exp_data.pop_front());
                                end
                        end
                end
        end

        always @(posedge clk) begin
                if (rst_n) begin
                        cycles++;
                        if (cycles >= TIMEOUT) begin
                                $display("timeout after %0d cycles, %0d of %0d stores seen",
                                         cycles, n_stores, n_exp);
                                $display("ERRORS FOUND");
                                $finish;
                        end
                end
        end

        initial begin
                rst_n       = 1'b0;
                ibus_stall  = 1'b0;
                dbus_stall  = 1'b0;
                ibus_rddata = '0;
                dbus_rddata = '0;
                for (int i = 0; i < 256; i++) begin
                        dmem[i]    = (i * 32'h0100_0193) ^ 32'hc3a5_0f1e;
                        ref_mem[i] = dmem[i];
                end
                for (int r = 0; r < 32; r++)
                        ref_regs[r] = '0;
                build_program();
                run_model();
                n_exp = exp_addr.size();
                repeat (10) @(posedge clk);
                #2;
                rst_n = 1'b1;
                wait (n_stores >= n_exp);
                repeat (20) @(posedge clk);     // catch any stray store
                if (n_stores != n_exp) begin
                        $display("store count is %0d but the program makes %0d",
                                 n_stores, n_exp);
                        count_errs++;
                end
                if (exp_load.size() != 0) begin
                        $display("%0d loads never reached the data bus", exp_load.size());
                        count_errs++;
                end
                $display("store errors %0d, load errors %0d, fetch errors %0d, count errors %0d",
                         store_errs, load_errs, fetch_errs, count_errs);
                if (store_errs + load_errs + fetch_errs + count_errs == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

// ==== tb.f ====
mips_pkg.sv
stage_reg.sv
pipe_ctrl.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
exec_unit.sv
mem_stage.sv
mips_core.sv
mips_assertions.sv
tb_mips.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips -f tb.f -o sim_mips &&
        ./obj_dir/sim_mips | tee sim.log &&
        grep -qx "NO ERRORS" sim.log &&
        echo "PASS" || { echo "FAIL"; exit 1; }
